/* src/nvram_pkg.sv */
/*
   Shared definitions for the SRAM backup design. Four image slots, sizes in whole
   KiB (at most 65535), 512-byte sectors. Register offsets are byte addresses on APB.
*/
`default_nettype none

package nvram_pkg;

   localparam int NUM_SLOTS = 4;
   localparam int RAM_AW    = 27;

   typedef logic [1:0]  slot_t;
   typedef logic [15:0] kb_size_t;
   typedef logic [31:0] byte_size_t;
   typedef logic [31:0] lba_t;
   typedef logic [8:0]  buf_addr_t;

   // ----------------------------------------
   // register map
   // ----------------------------------------
   localparam logic [7:0] REG_CTRL     = 8'h00;
   localparam logic [7:0] REG_STATUS   = 8'h04;
   localparam logic [7:0] REG_BASE0    = 8'h10;
   localparam logic [7:0] REG_SIZE0    = 8'h14;
   localparam logic [7:0] REG_IMGSIZE0 = 8'h40;

   // base and size registers are interleaved, image sizes are packed
   localparam int REG_SLOT_STRIDE = 8;
   localparam int REG_IMG_STRIDE  = 4;

   // CTRL bits
   localparam int CTRL_LOAD_BIT = 0;
   localparam int CTRL_SAVE_BIT = 1;

endpackage

`default_nettype wire

/* src/nvram_apb_regs.sv */
/*
   APB slave without wait states, pready tied high and pslverr tied low.
   Writes land on the access-phase edge, reads are combinational from paddr.
   CTRL reads as 0; only the low 16 bits of the size registers exist.
*/
`timescale 1ns/100ps
`default_nettype none

module nvram_apb_regs (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [7:0]                          paddr,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [31:0]                         pwdata,
   output logic [31:0]                         prdata,
   output logic                                pready,
   output logic                                pslverr,
   output logic                                load_start,
   output logic                                save_start,
   output logic [31:0]                         slot_base [nvram_pkg::NUM_SLOTS],
   output nvram_pkg::kb_size_t                 slot_size [nvram_pkg::NUM_SLOTS],
   input  logic [nvram_pkg::NUM_SLOTS-1:0]     pend_load,
   input  logic [nvram_pkg::NUM_SLOTS-1:0]     pend_save,
   input  nvram_pkg::byte_size_t               image_size [nvram_pkg::NUM_SLOTS]
);
   import nvram_pkg::*;

   logic wr_en;
   logic busy;

   assign wr_en   = psel & penable & pwrite;
   assign pready  = 1'b1;
   assign pslverr = 1'b0;

   // busy while any slot still has a load or a save outstanding
   assign busy = |{pend_load, pend_save};

   // ----------------------------------------
   // write side
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         load_start <= 1'b0;
         save_start <= 1'b0;
         for (int i = 0; i < NUM_SLOTS; i++) begin
            slot_base[i] <= '0;
            slot_size[i] <= '0;
         end
      end else begin
         load_start <= wr_en && (paddr == REG_CTRL) && pwdata[CTRL_LOAD_BIT];
         save_start <= wr_en && (paddr == REG_CTRL) && pwdata[CTRL_SAVE_BIT];
         for (int i = 0; i < NUM_SLOTS; i++) begin
            if (wr_en && (paddr == REG_BASE0 + 8'(REG_SLOT_STRIDE * i))) begin
               slot_base[i] <= pwdata;
            end
            if (wr_en && (paddr == REG_SIZE0 + 8'(REG_SLOT_STRIDE * i))) begin
               slot_size[i] <= pwdata[15:0];
            end
         end
      end
   end

   // ----------------------------------------
   // read side
   // ----------------------------------------
   always_comb begin
      prdata = '0;
      if (paddr == REG_STATUS) begin
         prdata = {16'd0, pend_save, pend_load, 7'd0, busy};
      end
      for (int i = 0; i < NUM_SLOTS; i++) begin
         if (paddr == REG_BASE0 + 8'(REG_SLOT_STRIDE * i)) begin
            prdata = slot_base[i];
         end
         if (paddr == REG_SIZE0 + 8'(REG_SLOT_STRIDE * i)) begin
            prdata = {16'd0, slot_size[i]};
         end
         if (paddr == REG_IMGSIZE0 + 8'(REG_IMG_STRIDE * i)) begin
            prdata = image_size[i];
         end
      end
   end

endmodule

`default_nettype wire

/* src/nvram_slot_scheduler.sv */
/*
   Keeps pending load and save bits per slot and walks the slots round robin.
   A slot stays active while it has work; a save is issued before a load.
*/
`timescale 1ns/100ps
`default_nettype none

module nvram_slot_scheduler (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                load_start,
   input  logic                                save_start,
   input  logic                                xfer_done,
   output nvram_pkg::slot_t                    active_slot,
   output logic                                xfer_rd,
   output logic                                xfer_wr,
   output logic [nvram_pkg::NUM_SLOTS-1:0]     pend_load,
   output logic [nvram_pkg::NUM_SLOTS-1:0]     pend_save
);
   import nvram_pkg::*;

   logic idle;

   assign idle = ~xfer_rd & ~xfer_wr;

   always_ff @(posedge clk) begin
      if (rst) begin
         pend_load   <= '0;
         pend_save   <= '0;
         active_slot <= '0;
         xfer_rd     <= 1'b0;
         xfer_wr     <= 1'b0;
      end else begin
         if (xfer_done) begin
            // retire the transfer that just ended in the active slot
            xfer_rd <= 1'b0;
            xfer_wr <= 1'b0;
            if (xfer_wr) begin
               pend_save[active_slot] <= 1'b0;
            end
            if (xfer_rd) begin
               pend_load[active_slot] <= 1'b0;
            end
         end else if (idle) begin
            if (pend_save[active_slot]) begin
               xfer_wr <= 1'b1;
            end else if (pend_load[active_slot]) begin
               xfer_rd <= 1'b1;
            end else begin
               // nothing here, look at the next slot (wraps after the last one)
               active_slot <= active_slot + slot_t'(1);
            end
         end

         // a new request re-arms every slot, even one that is just finishing
         if (load_start) begin
            pend_load <= '1;
         end
         if (save_start) begin
            pend_save <= '1;
         end
      end
   end

endmodule

`default_nettype wire

/* src/nvram_image_table.sv */
/*
   Mount record per slot. A pulse on img_mounted latches readonly and size for
   that slot. After a save the active slot's size becomes new_size_kb * 1024.
*/
`timescale 1ns/100ps
`default_nettype none

module nvram_image_table (
   input  logic                                clk,
   input  logic                                rst,
   input  logic [nvram_pkg::NUM_SLOTS-1:0]     img_mounted,
   input  logic                                img_readonly,
   input  nvram_pkg::byte_size_t               img_size,
   input  nvram_pkg::slot_t                    active_slot,
   input  logic                                size_update,
   input  nvram_pkg::kb_size_t                 new_size_kb,
   output logic                                mounted_rw,
   output nvram_pkg::byte_size_t               image_size [nvram_pkg::NUM_SLOTS],
   output nvram_pkg::byte_size_t               act_image_size
);
   import nvram_pkg::*;

   logic [NUM_SLOTS-1:0] mounted;
   logic [NUM_SLOTS-1:0] readonly;

   always_ff @(posedge clk) begin
      if (rst) begin
         mounted  <= '0;
         readonly <= '0;
         for (int i = 0; i < NUM_SLOTS; i++) begin
            image_size[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_SLOTS; i++) begin
            if (img_mounted[i]) begin
               mounted[i]    <= 1'b1;
               readonly[i]   <= img_readonly;
               image_size[i] <= img_size;
            end
         end
         // a finished save wins over a mount in the same cycle
         if (size_update) begin
            image_size[active_slot] <= byte_size_t'({new_size_kb, 10'd0});
         end
      end
   end

   assign mounted_rw     = mounted[active_slot] & ~readonly[active_slot];
   assign act_image_size = image_size[active_slot];

endmodule

`default_nettype wire

/* src/nvram_block_mover.sv */
/*
   Moves whole sectors between the SD buffer port and RAM, starting at sector 0.
   RAM has one cycle of read latency; ram_aw must not exceed 32.
   Ineligible slots finish one cycle after they become active, without SD strobes.
*/
`timescale 1ns/100ps
`default_nettype none

module nvram_block_mover #(
   parameter int ram_aw = nvram_pkg::RAM_AW
) (
   input  logic                                clk,
   input  logic                                rst,
   input  nvram_pkg::slot_t                    active_slot,
   input  logic                                xfer_rd,
   input  logic                                xfer_wr,
   input  logic [31:0]                         slot_base [nvram_pkg::NUM_SLOTS],
   input  nvram_pkg::kb_size_t                 slot_size [nvram_pkg::NUM_SLOTS],
   input  logic                                mounted_rw,
   input  nvram_pkg::byte_size_t               act_image_size,
   output logic                                xfer_done,
   output logic                                size_update,
   output nvram_pkg::lba_t                     sd_lba,
   output logic [nvram_pkg::NUM_SLOTS-1:0]     sd_rd,
   output logic [nvram_pkg::NUM_SLOTS-1:0]     sd_wr,
   input  logic [nvram_pkg::NUM_SLOTS-1:0]     sd_ack,
   input  nvram_pkg::buf_addr_t                sd_buff_addr,
   input  logic [7:0]                          sd_buff_dout,
   output logic [7:0]                          sd_buff_din,
   output logic [ram_aw-1:0]                   ram_addr,
   output logic                                ram_we,
   output logic [7:0]                          ram_din,
   input  logic [7:0]                          ram_dout
);
   import nvram_pkg::*;

   typedef enum logic [1:0] {st_idle, st_process, st_finish} state_t;

   state_t      state;
   lba_t        last_lba;
   logic        last_ack;
   logic        eligible;
   logic        ack_fall;
   logic [31:0] byte_addr;

   // a load also needs an image that holds data
   assign eligible = mounted_rw && (slot_size[active_slot] != '0) &&
                     (xfer_wr || (act_image_size != '0));

   assign ack_fall = last_ack & ~sd_ack[active_slot];

   // ----------------------------------------
   // transfer FSM
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= st_idle;
         xfer_done   <= 1'b0;
         size_update <= 1'b0;
         sd_rd       <= '0;
         sd_wr       <= '0;
         last_ack    <= 1'b0;
      end else begin
         xfer_done   <= 1'b0;
         size_update <= 1'b0;
         last_ack    <= sd_ack[active_slot];
         case (state)
            st_idle: begin
               if (xfer_rd || xfer_wr) begin
                  if (eligible) begin
                     sd_rd[active_slot] <= xfer_rd;
                     sd_wr[active_slot] <= xfer_wr;
                     state              <= st_process;
                  end else begin
                     xfer_done <= 1'b1;
                     state     <= st_finish;
                  end
               end
            end
            st_process: begin
               if (ack_fall && (sd_lba == last_lba)) begin
                  sd_rd       <= '0;
                  sd_wr       <= '0;
                  xfer_done   <= 1'b1;
                  size_update <= xfer_wr;
                  state       <= st_finish;
               end
            end
            // holds off one cycle so the scheduler can drop its request
            st_finish: state <= st_idle;
            default:   state <= st_idle;
         endcase
      end
   end

   // sector counter, two sectors per KiB
   always_ff @(posedge clk) begin
      if (state == st_idle) begin
         sd_lba   <= '0;
         last_lba <= lba_t'({slot_size[active_slot], 1'b0}) - lba_t'(1);
      end else if (state == st_process && ack_fall && sd_lba != last_lba) begin
         sd_lba <= sd_lba + lba_t'(1);
      end
   end

   // ----------------------------------------
   // RAM side
   // ----------------------------------------
   assign byte_addr = slot_base[active_slot] + {sd_lba[22:0], 9'd0} +
                      {23'd0, sd_buff_addr};
   assign ram_addr  = byte_addr[ram_aw-1:0];
   assign ram_we    = sd_rd[active_slot] & sd_ack[active_slot];
   assign ram_din   = sd_buff_dout;

   // the host samples this a cycle after it presents the address
   assign sd_buff_din = ram_dout;

endmodule

`default_nettype wire

/* src/nvram_backup_top.sv */
/*
   SRAM backup to SD image slots, controlled over APB.
   The SD card controller sits outside; it answers on the per-slot ack lines.
*/
`timescale 1ns/100ps
`default_nettype none

module nvram_backup_top #(
   parameter int ram_aw = nvram_pkg::RAM_AW
) (
   input  logic                                clk,
   input  logic                                rst,
   // APB
   input  logic [7:0]                          paddr,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [31:0]                         pwdata,
   output logic [31:0]                         prdata,
   output logic                                pready,
   output logic                                pslverr,
   // image mount
   input  logic [nvram_pkg::NUM_SLOTS-1:0]     img_mounted,
   input  logic                                img_readonly,
   input  nvram_pkg::byte_size_t               img_size,
   // SD block port
   output nvram_pkg::lba_t                     sd_lba,
   output logic [nvram_pkg::NUM_SLOTS-1:0]     sd_rd,
   output logic [nvram_pkg::NUM_SLOTS-1:0]     sd_wr,
   input  logic [nvram_pkg::NUM_SLOTS-1:0]     sd_ack,
   input  nvram_pkg::buf_addr_t                sd_buff_addr,
   input  logic [7:0]                          sd_buff_dout,
   output logic [7:0]                          sd_buff_din,
   // RAM port
   output logic [ram_aw-1:0]                   ram_addr,
   output logic                                ram_we,
   output logic [7:0]                          ram_din,
   input  logic [7:0]                          ram_dout
);
   import nvram_pkg::*;

   logic                 load_start;
   logic                 save_start;
   logic [31:0]          slot_base [NUM_SLOTS];
   kb_size_t             slot_size [NUM_SLOTS];
   logic [NUM_SLOTS-1:0] pend_load;
   logic [NUM_SLOTS-1:0] pend_save;
   byte_size_t           image_size [NUM_SLOTS];
   byte_size_t           act_image_size;
   slot_t                active_slot;
   logic                 xfer_rd;
   logic                 xfer_wr;
   logic                 xfer_done;
   logic                 size_update;
   logic                 mounted_rw;

   nvram_apb_regs u_regs (
      .clk        (clk),
      .rst        (rst),
      .paddr      (paddr),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .load_start (load_start),
      .save_start (save_start),
      .slot_base  (slot_base),
      .slot_size  (slot_size),
      .pend_load  (pend_load),
      .pend_save  (pend_save),
      .image_size (image_size)
   );

   nvram_slot_scheduler u_scheduler (
      .clk         (clk),
      .rst         (rst),
      .load_start  (load_start),
      .save_start  (save_start),
      .xfer_done   (xfer_done),
      .active_slot (active_slot),
      .xfer_rd     (xfer_rd),
      .xfer_wr     (xfer_wr),
      .pend_load   (pend_load),
      .pend_save   (pend_save)
   );

   // a save records the configured size of the slot it just wrote
   nvram_image_table u_image_table (
      .clk            (clk),
      .rst            (rst),
      .img_mounted    (img_mounted),
      .img_readonly   (img_readonly),
      .img_size       (img_size),
      .active_slot    (active_slot),
      .size_update    (size_update),
      .new_size_kb    (slot_size[active_slot]),
      .mounted_rw     (mounted_rw),
      .image_size     (image_size),
      .act_image_size (act_image_size)
   );

   nvram_block_mover #(
      .ram_aw (ram_aw)
   ) u_mover (
      .clk            (clk),
      .rst            (rst),
      .active_slot    (active_slot),
      .xfer_rd        (xfer_rd),
      .xfer_wr        (xfer_wr),
      .slot_base      (slot_base),
      .slot_size      (slot_size),
      .mounted_rw     (mounted_rw),
      .act_image_size (act_image_size),
      .xfer_done      (xfer_done),
      .size_update    (size_update),
      .sd_lba         (sd_lba),
      .sd_rd          (sd_rd),
      .sd_wr          (sd_wr),
      .sd_ack         (sd_ack),
      .sd_buff_addr   (sd_buff_addr),
      .sd_buff_dout   (sd_buff_dout),
      .sd_buff_din    (sd_buff_din),
      .ram_addr       (ram_addr),
      .ram_we         (ram_we),
      .ram_din        (ram_din),
      .ram_dout       (ram_dout)
   );

endmodule

`default_nettype wire

/* bench/sd_host_model.sv */
/*
   Behavioral SD host and byte-wide RAM for the backup testbench.
   Each slot has a 4 KiB image, so slot sizes above 4 KiB are not modeled.
   Every transfer is logged as slot and direction, in the order it starts.
*/
`timescale 1ns/100ps
`default_nettype none

module sd_host_model #(
   parameter int ram_aw = 16
) (
   input  logic                                clk,
   input  nvram_pkg::lba_t                     sd_lba,
   input  logic [nvram_pkg::NUM_SLOTS-1:0]     sd_rd,
   input  logic [nvram_pkg::NUM_SLOTS-1:0]     sd_wr,
   output logic [nvram_pkg::NUM_SLOTS-1:0]     sd_ack,
   output nvram_pkg::buf_addr_t                sd_buff_addr,
   output logic [7:0]                          sd_buff_dout,
   input  logic [7:0]                          sd_buff_din,
   input  logic [ram_aw-1:0]                   ram_addr,
   input  logic                                ram_we,
   input  logic [7:0]                          ram_din,
   output logic [7:0]                          ram_dout
);
   import nvram_pkg::*;

   localparam int IMG_BYTES = 4096;

   logic [7:0] ram [2**ram_aw];
   logic [7:0] image [NUM_SLOTS][IMG_BYTES];
   int         log_slot [64];
   logic       log_save [64];
   int         log_count;

   initial begin
      // fill pattern mixes both address bytes so shifted copies show up
      for (int a = 0; a < 2**ram_aw; a++) begin
         ram[a] = 8'(a ^ (a >> 8) ^ 32'h5a);
      end
      for (int s = 0; s < NUM_SLOTS; s++) begin
         for (int i = 0; i < IMG_BYTES; i++) begin
            image[s][i] = 8'h00;
         end
      end
      log_count    = 0;
      sd_ack       = '0;
      sd_buff_addr = '0;
      sd_buff_dout = '0;
      ram_dout     = '0;
   end

   // RAM with one cycle of read latency
   always @(posedge clk) begin
      if (ram_we) begin
         ram[ram_addr] <= ram_din;
      end
      ram_dout <= ram[ram_addr];
   end

   // ----------------------------------------
   // SD side, one sector per ack pulse
   // ----------------------------------------
   always begin : host_loop
      int   slot;
      logic is_save;
      int   offs;
      @(negedge clk);
      if ((sd_rd | sd_wr) != '0) begin
         slot = 0;
         for (int i = 0; i < NUM_SLOTS; i++) begin
            if (sd_rd[i] || sd_wr[i]) begin
               slot = i;
            end
         end
         is_save             = |sd_wr;
         log_slot[log_count] = slot;
         log_save[log_count] = is_save;
         log_count++;
         while (sd_rd[slot] || sd_wr[slot]) begin
            offs = int'(sd_lba) * 512;
            // on a save the byte for address j-1 arrives while j is presented
            for (int j = 0; j <= 512; j++) begin
               if (is_save && j > 0) begin
                  image[slot][offs + j - 1] = sd_buff_din;
               end
               if (j < 512) begin
                  sd_ack[slot] = 1'b1;
                  sd_buff_addr = buf_addr_t'(j);
                  sd_buff_dout = image[slot][offs + j];
                  @(negedge clk);
               end
            end
            sd_ack = '0;
            // the mover steps the sector on the edge after ack falls
            @(negedge clk);
         end
      end
   end

endmodule

`default_nettype wire

/* bench/tb_nvram_backup.sv */
/*
   Directed tests for the SRAM backup design with RAM narrowed to 16 address bits.
   Slot sizes stay within the 4 KiB image area of the host model.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_nvram_backup;
   import nvram_pkg::*;

   localparam int TB_RAM_AW = 16;
   localparam int MAX_POLLS = 20000;

   logic                 clk;
   logic                 rst;
   logic [7:0]           paddr;
   logic                 psel;
   logic                 penable;
   logic                 pwrite;
   logic [31:0]          pwdata;
   logic [31:0]          prdata;
   logic                 pready;
   logic                 pslverr;
   logic [NUM_SLOTS-1:0] img_mounted;
   logic                 img_readonly;
   byte_size_t           img_size;
   lba_t                 sd_lba;
   logic [NUM_SLOTS-1:0] sd_rd;
   logic [NUM_SLOTS-1:0] sd_wr;
   logic [NUM_SLOTS-1:0] sd_ack;
   buf_addr_t            sd_buff_addr;
   logic [7:0]           sd_buff_dout;
   logic [7:0]           sd_buff_din;
   logic [TB_RAM_AW-1:0] ram_addr;
   logic                 ram_we;
   logic [7:0]           ram_din;
   logic [7:0]           ram_dout;
   logic [31:0]          rng_state;

   nvram_backup_top #(
      .ram_aw (TB_RAM_AW)
   ) u_nvram_backup_top (
      .clk          (clk),
      .rst          (rst),
      .paddr        (paddr),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .img_mounted  (img_mounted),
      .img_readonly (img_readonly),
      .img_size     (img_size),
      .sd_lba       (sd_lba),
      .sd_rd        (sd_rd),
      .sd_wr        (sd_wr),
      .sd_ack       (sd_ack),
      .sd_buff_addr (sd_buff_addr),
      .sd_buff_dout (sd_buff_dout),
      .sd_buff_din  (sd_buff_din),
      .ram_addr     (ram_addr),
      .ram_we       (ram_we),
      .ram_din      (ram_din),
      .ram_dout     (ram_dout)
   );

   sd_host_model #(
      .ram_aw (TB_RAM_AW)
   ) u_host (
      .clk          (clk),
      .sd_lba       (sd_lba),
      .sd_rd        (sd_rd),
      .sd_wr        (sd_wr),
      .sd_ack       (sd_ack),
      .sd_buff_addr (sd_buff_addr),
      .sd_buff_dout (sd_buff_dout),
      .sd_buff_din  (sd_buff_din),
      .ram_addr     (ram_addr),
      .ram_we       (ram_we),
      .ram_din      (ram_din),
      .ram_dout     (ram_dout)
   );

   always #2 clk = ~clk;

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic check_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   // prdata is sampled inside the access phase, before the edge that ends it
   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      #1;
      data    = prdata;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic wait_until_idle(input string what);
      logic [31:0] status;
      int          polls;
      polls = 0;
      apb_read(REG_STATUS, status);
      while (status[0] && polls < MAX_POLLS) begin
         apb_read(REG_STATUS, status);
         polls++;
      end
      assert (!status[0]) else begin
         $display("timed out at %0t ns waiting for busy to clear after the %s", $time, what);
         $display("TEST FAILED");
         $fatal(1, "controller never went idle");
      end
   endtask

   task automatic set_slot(input int slot, input logic [31:0] base, input int kb);
      apb_write(REG_BASE0 + 8'(8 * slot), base);
      apb_write(REG_SIZE0 + 8'(8 * slot), 32'(kb));
   endtask

   task automatic mount_image(input int slot, input logic ro, input logic [31:0] bytes);
      @(negedge clk);
      img_mounted  = NUM_SLOTS'(1) << slot;
      img_readonly = ro;
      img_size     = bytes;
      @(negedge clk);
      img_mounted  = '0;
   endtask

   task automatic compare_image(input int slot, input int base, input int bytes);
      for (int i = 0; i < bytes; i++) begin
         check_equal($sformatf("slot %0d image byte %0d", slot, i),
                     u_host.image[slot][i], u_host.ram[base + i]);
      end
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic register_access();
      logic [31:0] rd;
      apb_read(REG_STATUS, rd);
      check_equal("status after reset", rd, 32'h0);
      for (int i = 0; i < NUM_SLOTS; i++) begin
         apb_write(REG_BASE0 + 8'(8 * i), 32'hc0de_0000 + 32'(i * 32'h111));
         apb_write(REG_SIZE0 + 8'(8 * i), 32'hffff_0000 | 32'(i + 1));
      end
      for (int i = 0; i < NUM_SLOTS; i++) begin
         apb_read(REG_BASE0 + 8'(8 * i), rd);
         check_equal($sformatf("base %0d", i), rd, 32'hc0de_0000 + 32'(i * 32'h111));
         apb_read(REG_SIZE0 + 8'(8 * i), rd);
         check_equal($sformatf("size %0d", i), rd, 32'(i + 1));
      end
      check_equal("pready", pready, 32'h1);
      check_equal("pslverr", pslverr, 32'h0);
   endtask

   task automatic save_to_image();
      logic [31:0] rd;
      int          start;
      set_slot(1, 32'h1000, 2);
      mount_image(1, 1'b0, 32'd0);
      start = u_host.log_count;
      apb_write(REG_CTRL, 32'h2);
      // slot 1 keeps its save pending until all four sectors are written
      apb_read(REG_STATUS, rd);
      check_equal("status during save", rd & 32'h0000_2f01, 32'h0000_2001);
      wait_until_idle("save");
      check_equal("save transfers", u_host.log_count - start, 1);
      check_equal("saved slot", u_host.log_slot[start], 1);
      check_equal("save direction", u_host.log_save[start], 1);
      compare_image(1, 32'h1000, 2048);
      apb_read(REG_IMGSIZE0 + 8'h4, rd);
      check_equal("image size 1", rd, 32'd2048);
   endtask

   task automatic load_from_image();
      logic [31:0] rd;
      int          start;
      set_slot(2, 32'h2000, 1);
      for (int i = 0; i < 1024; i++) begin
         rng_state          = xorshift32(rng_state);
         u_host.image[2][i] = rng_state[7:0];
      end
      mount_image(2, 1'b0, 32'd1024);
      start = u_host.log_count;
      apb_write(REG_CTRL, 32'h1);
      // slot 2 keeps its load pending until both sectors are read
      apb_read(REG_STATUS, rd);
      check_equal("status during load", rd & 32'h0000_f401, 32'h0000_0401);
      wait_until_idle("load");
      // slot 1 still holds its saved image and is loaded as well
      check_equal("load transfers", u_host.log_count - start, 2);
      for (int k = start; k < start + 2; k++) begin
         check_equal("load direction", u_host.log_save[k], 0);
      end
      compare_image(2, 32'h2000, 1024);
   endtask

   task automatic skipped_slots();
      logic [31:0] rd;
      int          start;
      set_slot(0, 32'h0000, 1);
      mount_image(0, 1'b1, 32'd1024);
      set_slot(1, 32'h1000, 0);
      set_slot(2, 32'h2000, 0);
      set_slot(3, 32'h3000, 1);
      start = u_host.log_count;
      apb_write(REG_CTRL, 32'h2);
      wait_until_idle("skipped save");
      apb_write(REG_CTRL, 32'h1);
      wait_until_idle("skipped load");
      check_equal("strobes on skipped slots", u_host.log_count - start, 0);
      apb_read(REG_STATUS, rd);
      check_equal("status after skips", rd, 32'h0);
      apb_read(REG_IMGSIZE0, rd);
      check_equal("readonly image size", rd, 32'd1024);
   endtask

   task automatic empty_image();
      logic [31:0] rd;
      int          start;
      mount_image(3, 1'b0, 32'd0);
      start = u_host.log_count;
      apb_write(REG_CTRL, 32'h1);
      wait_until_idle("load from empty image");
      check_equal("load from empty image", u_host.log_count - start, 0);
      apb_write(REG_CTRL, 32'h2);
      wait_until_idle("save to empty image");
      check_equal("save transfers", u_host.log_count - start, 1);
      check_equal("saved slot", u_host.log_slot[start], 3);
      check_equal("save direction", u_host.log_save[start], 1);
      compare_image(3, 32'h3000, 1024);
      apb_read(REG_IMGSIZE0 + 8'hc, rd);
      check_equal("image size 3", rd, 32'd1024);
   endtask

   task automatic combined_requests();
      int start;
      int n;
      int groups;
      int drops;
      int saves [NUM_SLOTS];
      int loads [NUM_SLOTS];
      set_slot(1, 32'h1000, 2);
      set_slot(2, 32'h2000, 1);
      start = u_host.log_count;
      apb_write(REG_CTRL, 32'h1);
      apb_write(REG_CTRL, 32'h2);
      wait_until_idle("combined requests");
      n      = u_host.log_count - start;
      groups = 1;
      drops  = 0;
      for (int s = 0; s < NUM_SLOTS; s++) begin
         saves[s] = 0;
         loads[s] = 0;
      end
      for (int k = start; k < start + n; k++) begin
         if (u_host.log_save[k]) saves[u_host.log_slot[k]]++;
         else loads[u_host.log_slot[k]]++;
         if (k > start && u_host.log_slot[k] != u_host.log_slot[k - 1]) begin
            groups++;
            if (u_host.log_slot[k] < u_host.log_slot[k - 1]) drops++;
            // only the slot already loading may run its load first
            check_equal("save before load", u_host.log_save[k], 1);
         end
      end
      // slot 0 is readonly, slots 1 to 3 get one save and one load each
      for (int s = 0; s < NUM_SLOTS; s++) begin
         check_equal($sformatf("saves of slot %0d", s), saves[s], (s == 0) ? 0 : 1);
         check_equal($sformatf("loads of slot %0d", s), loads[s], (s == 0) ? 0 : 1);
      end
      check_equal("slot groups", groups, 3);
      check_equal("round robin order",
                  (drops == 0) || (drops == 1 &&
                  u_host.log_slot[start + n - 1] < u_host.log_slot[start]), 1);
   endtask

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      paddr        = '0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      pwdata       = '0;
      img_mounted  = '0;
      img_readonly = 1'b0;
      img_size     = '0;
      rng_state    = 32'h70e2_275a;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      register_access();
      save_to_image();
      load_from_image();
      skipped_slots();
      empty_image();
      combined_requests();
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
src/nvram_pkg.sv
src/nvram_apb_regs.sv
src/nvram_slot_scheduler.sv
src/nvram_image_table.sv
src/nvram_block_mover.sv
src/nvram_backup_top.sv
bench/sd_host_model.sv
bench/tb_nvram_backup.sv

/* Bender.yml */
package:
  name: nvram_backup

sources:
  - src/nvram_pkg.sv
  - src/nvram_apb_regs.sv
  - src/nvram_slot_scheduler.sv
  - src/nvram_image_table.sv
  - src/nvram_block_mover.sv
  - src/nvram_backup_top.sv
  - target: test
    files:
      - bench/sd_host_model.sv
      - bench/tb_nvram_backup.sv
